// File: list.f
+incdir+logic
logic/dcache_pkg.sv
logic/dcache_setup.sv
logic/dcache_memory.sv
logic/dcache_hit.sv
logic/dcache_biu_ctrl.sv
logic/dcache_core.sv
testbench/tb_biu_model.sv
testbench/tb_dcache.sv

// File: run.sh
#!/bin/sh
# Build and run the data cache testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module tb_dcache -f list.f \
  && ./obj_dir/Vtb_dcache | tee sim.log \
  && grep -qF '*** PASSED ***' sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

// File: testbench/tb_dcache.sv
// Data cache testbench top
//   Clock, reset, DUT and behavioral BIU
//   Four-phase CPU and flush tasks against a reference memory image
//   Miss/hit, write-through, non-cacheable, two-way and flush checks
//   Watchdog and final report
`timescale 1ns/1ps
`default_nettype none

module tb_dcache;

  localparam int          CLK_NS      = 40;
  localparam int          RST_CYCLES  = 8;
  localparam int          WDOG_CYCLES = 20000;  // Far above the directed sequence
  localparam logic [31:0] SEED        = 32'h7e5a_2aad;

  logic              clk_i = 1'b0;
  logic              rst_ni;
  logic              mem_req, mem_we, is_cacheable, mem_ack, cache_flush, cache_flush_rdy;
  dcache_pkg::word_t mem_adr, mem_d, mem_q;
  logic              biu_stb, biu_stb_ack, biu_we, biu_burst, biu_ack, proto_err;
  dcache_pkg::word_t biu_adri, biu_d, biu_q, last_adr, last_d;
  logic              last_we, last_burst;
  int                stb_cnt, burst_cnt;
  dcache_pkg::word_t ref_mem [256];   // Expected memory contents

  always #(CLK_NS/2) clk_i = ~clk_i;

  dcache_core dut_i (
    .clk_i, .rst_ni, .mem_req_i(mem_req), .mem_adr_i(mem_adr), .mem_we_i(mem_we),
    .mem_d_i(mem_d), .is_cacheable_i(is_cacheable), .mem_q_o(mem_q), .mem_ack_o(mem_ack),
    .cache_flush_i(cache_flush), .cache_flush_rdy_o(cache_flush_rdy),
    .biu_stb_o(biu_stb), .biu_stb_ack_i(biu_stb_ack), .biu_adri_o(biu_adri),
    .biu_we_o(biu_we), .biu_d_o(biu_d), .biu_burst_o(biu_burst),
    .biu_ack_i(biu_ack), .biu_q_i(biu_q)
  );

  tb_biu_model biu_i (
    .clk_i, .rst_ni, .biu_stb_i(biu_stb), .biu_adri_i(biu_adri), .biu_we_i(biu_we),
    .biu_d_i(biu_d), .biu_burst_i(biu_burst), .biu_stb_ack_o(biu_stb_ack),
    .biu_ack_o(biu_ack), .biu_q_o(biu_q), .stb_cnt_o(stb_cnt), .burst_cnt_o(burst_cnt),
    .last_adr_o(last_adr), .last_we_o(last_we), .last_d_o(last_d),
    .last_burst_o(last_burst), .proto_err_o(proto_err)
  );

  // ----------------------------------------
  // Reporting and helpers
  // ----------------------------------------
  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("*** FAILED ***");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  function automatic string fail_line(input string msg);
    return $sformatf("[FAIL] %0t ns: %s", $time, msg);
  endfunction

  // Tag above bit 8, set index in bits 7:4, word in bits 3:2
  function automatic dcache_pkg::word_t line_adr(input int tag, input int idx, input int offs);
    return dcache_pkg::word_t'(tag * 256 + idx * 16 + offs * 4);
  endfunction

  task automatic next_cycle();
    @(posedge clk_i);
    #2;
  endtask

  // ----------------------------------------
  // Concurrent checks
  // ----------------------------------------
  assert property (@(posedge clk_i) !rst_ni |-> (!mem_ack && !biu_stb && !cache_flush_rdy))
    else stop_with_failure(fail_line("output active during reset"));
  assert property (@(posedge clk_i) disable iff (!rst_ni) !proto_err)
    else stop_with_failure("The bus model saw a BIU protocol violation");
  assert property (@(posedge clk_i) disable iff (!rst_ni) !(mem_ack && cache_flush_rdy))
    else stop_with_failure(fail_line("CPU ack and flush ready high together"));

  // ----------------------------------------
  // CPU and flush four-phase tasks
  // ----------------------------------------
  // lat counts edges from capture to ack
  task automatic cpu_access(input dcache_pkg::word_t adr, input logic we,
                            input dcache_pkg::word_t d, input logic cacheable,
                            output dcache_pkg::word_t q, output int lat);
    mem_adr      = adr;
    mem_we       = we;
    mem_d        = d;
    is_cacheable = cacheable;
    mem_req      = 1'b1;
    lat          = -1;                       // First edge captures
    do begin
      next_cycle();
      lat++;
    end while (!mem_ack);
    q       = mem_q;
    mem_req = 1'b0;
    do next_cycle(); while (mem_ack);       // Ack must fall before next request
  endtask

  // exp_stb of -1 allows either a hit or one refill
  task automatic check_read(input dcache_pkg::word_t adr, input logic cacheable,
                            input int exp_stb);
    dcache_pkg::word_t q;
    int                lat, stb0, burst0;
    stb0   = stb_cnt;
    burst0 = burst_cnt;
    cpu_access(adr, 1'b0, '0, cacheable, q, lat);
    assert (q == ref_mem[adr[9:2]]) else stop_with_failure(fail_line($sformatf(
      "read %h returned %h, expected %h", adr, q, ref_mem[adr[9:2]])));
    if (exp_stb >= 0) begin
      assert (stb_cnt - stb0 == exp_stb) else stop_with_failure(fail_line($sformatf(
        "read %h made %0d strobes, expected %0d", adr, stb_cnt - stb0, exp_stb)));
    end
    if (stb_cnt != stb0) begin
      assert (stb_cnt - stb0 == 1 && burst_cnt - burst0 == int'(cacheable) && !last_we &&
              last_adr == (cacheable ? {adr[31:4], 4'h0} : adr))
        else stop_with_failure(fail_line($sformatf("wrong bus transfer for read %h", adr)));
    end else begin
      assert (lat == 2) else stop_with_failure(fail_line($sformatf(
        "read hit %h acked %0d cycles after capture", adr, lat)));
    end
  endtask

  task automatic check_write(input dcache_pkg::word_t adr, input dcache_pkg::word_t d,
                             input logic cacheable);
    dcache_pkg::word_t q;
    int                lat, stb0;
    stb0 = stb_cnt;
    cpu_access(adr, 1'b1, d, cacheable, q, lat);
    ref_mem[adr[9:2]] = d;
    assert (stb_cnt - stb0 == 1 && last_we && !last_burst && last_adr == adr && last_d == d)
      else stop_with_failure(fail_line($sformatf("wrong bus transfer for write %h", adr)));
  endtask

  task automatic flush_cache();
    cache_flush = 1'b1;
    do next_cycle(); while (!cache_flush_rdy);
    cache_flush = 1'b0;
    do next_cycle(); while (cache_flush_rdy);
  endtask

  // ----------------------------------------
  // Watchdog
  // ----------------------------------------
  initial begin
    #(WDOG_CYCLES * CLK_NS);
    stop_with_failure($sformatf("Watchdog timeout, run still active after %0d cycles",
                                WDOG_CYCLES));
  end

  // ----------------------------------------
  // Directed sequence
  // ----------------------------------------
  initial begin
    void'($urandom(SEED));
    rst_ni       = 1'b1;
    mem_req      = 1'b0;
    mem_adr      = '0;
    mem_we       = 1'b0;
    mem_d        = '0;
    is_cacheable = 1'b0;
    cache_flush  = 1'b0;
    #1 rst_ni = 1'b0;                       // Clean falling edge
    repeat (RST_CYCLES) @(posedge clk_i);
    #2 rst_ni = 1'b1;
    next_cycle();
    assert (!mem_ack && !biu_stb && !cache_flush_rdy)
      else stop_with_failure(fail_line("output active right after reset"));
    for (int i = 0; i < 256; i++) ref_mem[i] = biu_i.mem[i];

    // Miss fills the line and the whole line then hits
    for (int i = 0; i < 4; i++) begin
      check_read(line_adr(0, i, 1), 1'b1, 1);
      for (int o = 0; o < 4; o++) check_read(line_adr(0, i, o), 1'b1, 0);
    end

    // Write hit updates the line and a write miss does not allocate
    check_write(line_adr(0, 0, 2), 32'hcafe_0001, 1'b1);
    check_read(line_adr(0, 0, 2), 1'b1, 0);
    check_write(line_adr(1, 5, 0), 32'hcafe_0002, 1'b1);
    check_read(line_adr(1, 5, 0), 1'b1, 1);
    check_write(line_adr(3, 12, 1), 32'hcafe_0003, 1'b0);
    check_read(line_adr(3, 12, 1), 1'b0, 1);

    // Non-cacheable reads bypass the cache even for a cached line
    for (int o = 0; o < 4; o++) check_read(line_adr(2, 6, o), 1'b0, 1);
    check_read(line_adr(0, 1, 3), 1'b0, 1);
    check_read(line_adr(2, 6, 2), 1'b1, 1);

    // Two ways in set 9 before a third line evicts one
    check_read(line_adr(0, 9, 0), 1'b1, 1);
    check_read(line_adr(1, 9, 1), 1'b1, 1);
    check_read(line_adr(0, 9, 2), 1'b1, 0);
    check_read(line_adr(1, 9, 3), 1'b1, 0);
    check_write(line_adr(1, 9, 3), 32'hcafe_0004, 1'b1);
    check_read(line_adr(1, 9, 3), 1'b1, 0);
    check_read(line_adr(2, 9, 0), 1'b1, 1);
    check_read(line_adr(2, 9, 1), 1'b1, 0);
    for (int t = 0; t < 3; t++) check_read(line_adr(t, 9, 3), 1'b1, -1);

    // Every earlier line misses again after a flush
    flush_cache();
    for (int i = 0; i < 4; i++) check_read(line_adr(0, i, 0), 1'b1, 1);
    check_read(line_adr(2, 6, 0), 1'b1, 1);
    check_read(line_adr(1, 5, 1), 1'b1, 1);
    check_read(line_adr(2, 9, 2), 1'b1, 1);

    $display("*** PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

// File: testbench/tb_biu_model.sv
// Behavioral BIU for the data cache testbench
//   256-word memory with random initial contents
//   Random 0 to 3 cycle delays before strobe ack and before each beat
//   Protocol checks, strobe counters, last-transfer record
`timescale 1ns/1ps
`default_nettype none

module tb_biu_model (
  input  wire logic              clk_i,
  input  wire logic              rst_ni,
  input  wire logic              biu_stb_i,
  input  wire dcache_pkg::word_t biu_adri_i,
  input  wire logic              biu_we_i,
  input  wire dcache_pkg::word_t biu_d_i,
  input  wire logic              biu_burst_i,
  output logic                   biu_stb_ack_o,
  output logic                   biu_ack_o,
  output dcache_pkg::word_t      biu_q_o,
  output int                     stb_cnt_o,     // All strobes accepted
  output int                     burst_cnt_o,   // Burst strobes only
  output dcache_pkg::word_t      last_adr_o,
  output logic                   last_we_o,
  output dcache_pkg::word_t      last_d_o,
  output logic                   last_burst_o,
  output logic                   proto_err_o    // Sticky protocol error
);

  dcache_pkg::word_t mem [256];

  // Drive point, 2 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk_i);
    #2;
  endtask

  task automatic flag_error(input string msg);
    $display("BIU model: %s at %0t ns", msg, $time);
    proto_err_o = 1'b1;
  endtask

  task automatic serve_strobe();
    int                n;
    logic [7:0]        widx;
    dcache_pkg::word_t adr;
    adr          = biu_adri_i;
    stb_cnt_o    = stb_cnt_o + 1;
    if (biu_burst_i) burst_cnt_o = burst_cnt_o + 1;
    last_adr_o   = adr;
    last_we_o    = biu_we_i;
    last_d_o     = biu_d_i;
    last_burst_o = biu_burst_i;
    if (adr[31:10] != '0 || adr[1:0] != 2'b00) flag_error("address outside the model memory");
    if (biu_burst_i && (biu_we_i || adr[3:0] != 4'h0)) flag_error("burst not an aligned read");
    // Strobe must hold still until accepted
    n = int'($urandom % 4);
    repeat (n) begin
      next_cycle();
      if (!biu_stb_i || biu_adri_i != adr) flag_error("strobe dropped or changed before ack");
    end
    biu_stb_ack_o = 1'b1;
    next_cycle();
    biu_stb_ack_o = 1'b0;
    // Data beats, incrementing from the line start
    for (int b = 0; b < (last_burst_o ? 4 : 1); b++) begin
      n = int'($urandom % 4);
      repeat (n) next_cycle();
      if (biu_stb_i) flag_error("new strobe during data beats");
      widx = adr[9:2] + 8'(b);
      if (last_we_o) mem[widx] = last_d_o;
      biu_q_o   = mem[widx];
      biu_ack_o = 1'b1;
      next_cycle();
      biu_ack_o = 1'b0;
    end
  endtask

  initial begin
    biu_stb_ack_o = 1'b0;
    biu_ack_o     = 1'b0;
    biu_q_o       = '0;
    stb_cnt_o     = 0;
    burst_cnt_o   = 0;
    last_adr_o    = '0;
    last_we_o     = 1'b0;
    last_d_o      = '0;
    last_burst_o  = 1'b0;
    proto_err_o   = 1'b0;
    #1;
    for (int i = 0; i < 256; i++) mem[i] = $urandom;   // After the seed is set
    forever begin
      next_cycle();
      if (rst_ni && biu_stb_i) serve_strobe();
    end
  end

endmodule

`default_nettype wire

// File: logic/dcache_core.sv
// Data cache top level
//   Setup, memory, front-end and bus-controller instances
//   CPU, flush and BIU ports
`timescale 1ns/1ps
`default_nettype none

module dcache_core (
  input  wire logic              clk_i,
  input  wire logic              rst_ni,

  // CPU side
  input  wire logic              mem_req_i,
  input  wire dcache_pkg::word_t mem_adr_i,
  input  wire logic              mem_we_i,
  input  wire dcache_pkg::word_t mem_d_i,
  input  wire logic              is_cacheable_i,
  output dcache_pkg::word_t      mem_q_o,
  output logic                   mem_ack_o,
  input  wire logic              cache_flush_i,     // Invalidate request
  output logic                   cache_flush_rdy_o,

  // BIU side
  output logic                   biu_stb_o,
  input  wire logic              biu_stb_ack_i,
  output dcache_pkg::word_t      biu_adri_o,
  output logic                   biu_we_o,
  output dcache_pkg::word_t      biu_d_o,
  output logic                   biu_burst_o,
  input  wire logic              biu_ack_i,
  input  wire dcache_pkg::word_t biu_q_i
);

  logic                  busy, setup_req, setup_we, setup_cacheable;
  dcache_pkg::word_t     setup_adr, setup_d;
  dcache_pkg::idx_t      rd_idx;
  dcache_pkg::tag_t      rd_tag;
  logic                  hit, flush_done, flush_start;
  dcache_pkg::ways_t     ways_hit, wr_ways;
  dcache_pkg::line_t     cache_line, biu_line;
  logic                  fill_we, wr_we, biucmd_ack;
  dcache_pkg::offs_t     wr_offs;
  dcache_pkg::word_t     wr_data, biu_word;
  dcache_pkg::biucmd_t   biucmd;

  dcache_setup setup_inst (
    .clk_i, .rst_ni, .mem_req_i, .busy_i(busy), .mem_adr_i, .mem_we_i, .mem_d_i, .is_cacheable_i,
    .req_o(setup_req), .adr_o(setup_adr), .we_o(setup_we), .d_o(setup_d),
    .cacheable_o(setup_cacheable), .rd_idx_o(rd_idx), .rd_tag_o(rd_tag)
  );

  dcache_memory memory_inst (
    .clk_i, .rst_ni, .rd_req_i(setup_req), .rd_idx_i(rd_idx), .rd_tag_i(rd_tag),
    .fill_we_i(fill_we), .fill_line_i(biu_line),
    .wr_we_i(wr_we), .wr_offs_i(wr_offs), .wr_data_i(wr_data), .wr_ways_i(wr_ways),
    .flush_start_i(flush_start),
    .hit_o(hit), .ways_hit_o(ways_hit), .cache_line_o(cache_line), .flush_done_o(flush_done)
  );

  dcache_hit hit_inst (
    .clk_i, .rst_ni, .req_i(setup_req), .adr_i(setup_adr), .we_i(setup_we), .d_i(setup_d),
    .cacheable_i(setup_cacheable), .hit_i(hit), .ways_hit_i(ways_hit),
    .cache_line_i(cache_line), .flush_done_i(flush_done),
    .biucmd_ack_i(biucmd_ack), .biu_line_i(biu_line), .biu_word_i(biu_word),
    .mem_req_i, .cache_flush_i, .mem_ack_o, .mem_q_o, .cache_flush_rdy_o,
    .busy_o(busy), .biucmd_o(biucmd), .fill_we_o(fill_we), .wr_we_o(wr_we),
    .wr_offs_o(wr_offs), .wr_data_o(wr_data), .wr_ways_o(wr_ways), .flush_start_o(flush_start)
  );

  dcache_biu_ctrl biu_ctrl_inst (
    .clk_i, .rst_ni, .biucmd_i(biucmd), .adr_i(setup_adr), .d_i(setup_d),
    .biu_stb_ack_i, .biu_ack_i, .biu_q_i,
    .biucmd_ack_o(biucmd_ack), .biu_line_o(biu_line), .biu_word_o(biu_word),
    .biu_stb_o, .biu_adri_o, .biu_we_o, .biu_d_o, .biu_burst_o
  );

endmodule

`default_nettype wire

// File: logic/dcache_biu_ctrl.sv
// Bus controller FSM
//   Single reads, single writes and four-beat line bursts
//   Strobe held until accepted, beats counted afterwards
//   Read beats shifted into the line buffer
`timescale 1ns/1ps
`default_nettype none

`include "dcache_consts.svh"

module dcache_biu_ctrl (
  input  wire logic                 clk_i,
  input  wire logic                 rst_ni,

  input  wire dcache_pkg::biucmd_t  biucmd_i,
  input  wire dcache_pkg::word_t    adr_i,
  input  wire dcache_pkg::word_t    d_i,

  input  wire logic                 biu_stb_ack_i,
  input  wire logic                 biu_ack_i,
  input  wire dcache_pkg::word_t    biu_q_i,

  output logic                      biucmd_ack_o,
  output dcache_pkg::line_t         biu_line_o,
  output dcache_pkg::word_t         biu_word_o,

  output logic                      biu_stb_o,
  output dcache_pkg::word_t         biu_adri_o,
  output logic                      biu_we_o,
  output dcache_pkg::word_t         biu_d_o,
  output logic                      biu_burst_o
);

  dcache_pkg::biu_state_t state;
  dcache_pkg::offs_t      beat_cnt;
  logic                   last_beat;

  assign last_beat    = biu_ack_i &
                        (~biu_burst_o | (beat_cnt == dcache_pkg::offs_t'(`DC_WORDS-1)));
  assign biucmd_ack_o = (state == dcache_pkg::BIU_DONE);
  assign biu_word_o   = biu_line_o[`DC_LINE_BITS-1 -: `DC_XLEN];  // Single beat lands on top

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state       <= dcache_pkg::BIU_IDLE;
      biu_stb_o   <= 1'b0;
      biu_we_o    <= 1'b0;
      biu_burst_o <= 1'b0;
      beat_cnt    <= '0;
    end else begin
      case (state)
        dcache_pkg::BIU_IDLE: begin
          if (biucmd_i != dcache_pkg::BIUCMD_NONE) begin
            biu_stb_o   <= 1'b1;
            biu_we_o    <= (biucmd_i == dcache_pkg::BIUCMD_WRITE_SINGLE);
            biu_burst_o <= (biucmd_i == dcache_pkg::BIUCMD_READ_BURST);
            beat_cnt    <= '0;
            state       <= dcache_pkg::BIU_STROBE;
          end
        end

        dcache_pkg::BIU_STROBE: begin
          if (biu_stb_ack_i) begin
            biu_stb_o <= 1'b0;
            state     <= dcache_pkg::BIU_BEATS;
          end
        end

        dcache_pkg::BIU_BEATS: begin
          if (biu_ack_i) beat_cnt <= beat_cnt + 1'b1;
          if (last_beat) state    <= dcache_pkg::BIU_DONE;
        end

        default: state <= dcache_pkg::BIU_IDLE;   // DONE lasts one cycle
      endcase
    end
  end

  // Transfer payload
  always_ff @(posedge clk_i) begin
    if (state == dcache_pkg::BIU_IDLE) begin
      biu_d_o <= d_i;
      if (biucmd_i == dcache_pkg::BIUCMD_READ_BURST)   // Line start
        biu_adri_o <= {adr_i[`DC_XLEN-1:`DC_BYTE_BITS+`DC_OFFS_BITS],
                       {(`DC_BYTE_BITS+`DC_OFFS_BITS){1'b0}}};
      else
        biu_adri_o <= adr_i;
    end
    if (state == dcache_pkg::BIU_BEATS && biu_ack_i)   // Word 0 ends at the bottom
      biu_line_o <= {biu_q_i, biu_line_o[`DC_LINE_BITS-1:`DC_XLEN]};
  end

endmodule

`default_nettype wire

// File: logic/dcache_hit.sv
// Front-end FSM
//   Classifies read hit, read miss, non-cacheable read and write
//   Word select from cache line or bus result
//   Bus command level, fill and write-hit strobes
//   CPU and flush four-phase handshakes
`timescale 1ns/1ps
`default_nettype none

`include "dcache_consts.svh"

module dcache_hit (
  input  wire logic                clk_i,
  input  wire logic                rst_ni,

  input  wire logic                req_i,
  input  wire dcache_pkg::word_t   adr_i,
  input  wire logic                we_i,
  input  wire dcache_pkg::word_t   d_i,
  input  wire logic                cacheable_i,

  input  wire logic                hit_i,
  input  wire dcache_pkg::ways_t   ways_hit_i,
  input  wire dcache_pkg::line_t   cache_line_i,
  input  wire logic                flush_done_i,

  input  wire logic                biucmd_ack_i,
  input  wire dcache_pkg::line_t   biu_line_i,
  input  wire dcache_pkg::word_t   biu_word_i,

  input  wire logic                mem_req_i,
  input  wire logic                cache_flush_i,

  output logic                     mem_ack_o,
  output dcache_pkg::word_t        mem_q_o,
  output logic                     cache_flush_rdy_o,

  output logic                     busy_o,
  output dcache_pkg::biucmd_t      biucmd_o,

  output logic                     fill_we_o,
  output logic                     wr_we_o,
  output dcache_pkg::offs_t        wr_offs_o,
  output dcache_pkg::word_t        wr_data_o,
  output dcache_pkg::ways_t        wr_ways_o,
  output logic                     flush_start_o
);

  dcache_pkg::hit_state_t state;
  dcache_pkg::offs_t      offs;
  logic                   bus_done;

  assign offs     = adr_i[`DC_BYTE_BITS +: `DC_OFFS_BITS];
  assign bus_done = (state == dcache_pkg::HIT_BUSWAIT) & biucmd_ack_i;

  assign busy_o        = (state != dcache_pkg::HIT_IDLE) | req_i;  // Blocks new capture
  assign flush_start_o = (state == dcache_pkg::HIT_IDLE) & cache_flush_i & ~mem_req_i & ~req_i;

  // Memory strobes
  assign fill_we_o = bus_done & (biucmd_o == dcache_pkg::BIUCMD_READ_BURST);
  assign wr_we_o   = (state == dcache_pkg::HIT_LOOKUP) & we_i & cacheable_i & hit_i;
  assign wr_offs_o = offs;
  assign wr_data_o = d_i;
  assign wr_ways_o = ways_hit_i;

  // --------------------------------------
  // FSM
  // --------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state             <= dcache_pkg::HIT_IDLE;
      mem_ack_o         <= 1'b0;
      cache_flush_rdy_o <= 1'b0;
      biucmd_o          <= dcache_pkg::BIUCMD_NONE;
    end else begin
      case (state)
        dcache_pkg::HIT_IDLE: begin
          if (req_i)              state <= dcache_pkg::HIT_LOOKUP;
          else if (flush_start_o) state <= dcache_pkg::HIT_FLUSH;
        end

        dcache_pkg::HIT_LOOKUP: begin
          if (we_i) begin                               // Always write through
            biucmd_o <= dcache_pkg::BIUCMD_WRITE_SINGLE;
            state    <= dcache_pkg::HIT_BUSWAIT;
          end else if (!cacheable_i) begin
            biucmd_o <= dcache_pkg::BIUCMD_READ_SINGLE;
            state    <= dcache_pkg::HIT_BUSWAIT;
          end else if (!hit_i) begin                    // Read miss, fetch line
            biucmd_o <= dcache_pkg::BIUCMD_READ_BURST;
            state    <= dcache_pkg::HIT_BUSWAIT;
          end else begin                                // Read hit
            mem_ack_o <= 1'b1;
            state     <= dcache_pkg::HIT_ACK;
          end
        end

        dcache_pkg::HIT_BUSWAIT: begin
          if (biucmd_ack_i) begin
            biucmd_o  <= dcache_pkg::BIUCMD_NONE;
            mem_ack_o <= 1'b1;
            state     <= dcache_pkg::HIT_ACK;
          end
        end

        dcache_pkg::HIT_ACK: begin
          if (!mem_req_i) begin                         // Drop ack one cycle after req
            mem_ack_o <= 1'b0;
            state     <= dcache_pkg::HIT_IDLE;
          end
        end

        dcache_pkg::HIT_FLUSH: begin
          if (flush_done_i) cache_flush_rdy_o <= 1'b1;
          if (cache_flush_rdy_o && !cache_flush_i) begin
            cache_flush_rdy_o <= 1'b0;
            state             <= dcache_pkg::HIT_IDLE;
          end
        end

        default: state <= dcache_pkg::HIT_IDLE;
      endcase
    end
  end

  // Read data, valid while ack is high
  always_ff @(posedge clk_i) begin
    if (state == dcache_pkg::HIT_LOOKUP) begin
      mem_q_o <= cache_line_i[offs*`DC_XLEN +: `DC_XLEN];
    end else if (bus_done) begin
      if (biucmd_o == dcache_pkg::BIUCMD_READ_BURST) mem_q_o <= biu_line_i[offs*`DC_XLEN +: `DC_XLEN];
      else                                           mem_q_o <= biu_word_i;
    end
  end

endmodule

`default_nettype wire

// File: logic/dcache_memory.sv
// Cache storage and lookup
//   Per-way tag, valid and data arrays
//   Tag compare against the latched lookup address
//   Line fill and write-hit word update
//   Invalidate sweep over all sets, random victim LFSR
`timescale 1ns/1ps
`default_nettype none

`include "dcache_consts.svh"

module dcache_memory (
  input  wire logic                clk_i,
  input  wire logic                rst_ni,

  input  wire logic                rd_req_i,
  input  wire dcache_pkg::idx_t    rd_idx_i,
  input  wire dcache_pkg::tag_t    rd_tag_i,

  input  wire logic                fill_we_i,
  input  wire dcache_pkg::line_t   fill_line_i,

  input  wire logic                wr_we_i,
  input  wire dcache_pkg::offs_t   wr_offs_i,
  input  wire dcache_pkg::word_t   wr_data_i,
  input  wire dcache_pkg::ways_t   wr_ways_i,

  input  wire logic                flush_start_i,

  output logic                     hit_o,
  output dcache_pkg::ways_t        ways_hit_o,
  output dcache_pkg::line_t        cache_line_o,
  output logic                     flush_done_o
);

  dcache_pkg::tag_t                          tag_mem  [`DC_WAYS][`DC_SETS];
  dcache_pkg::line_t                         data_mem [`DC_WAYS][`DC_SETS];
  logic [`DC_WAYS-1:0][`DC_SETS-1:0]         valid_q;

  dcache_pkg::idx_t                          lat_idx;   // Index of current lookup
  dcache_pkg::tag_t                          lat_tag;
  dcache_pkg::ways_t                         fill_way;
  logic [`DC_LFSR_BITS-1:0]                  lfsr;
  logic                                      flushing;
  dcache_pkg::idx_t                          flush_cnt;

  // --------------------------------------
  // Lookup and compare
  // --------------------------------------
  always_comb begin
    cache_line_o = '0;
    for (int w = 0; w < `DC_WAYS; w++) begin
      ways_hit_o[w] = valid_q[w][lat_idx] & (tag_mem[w][lat_idx] == lat_tag);
      if (ways_hit_o[w]) cache_line_o = cache_line_o | data_mem[w][lat_idx];
    end
  end

  assign hit_o = |ways_hit_o;

  // --------------------------------------
  // Victim selection
  // --------------------------------------
  // XNOR feedback, all-zero reset state is legal
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni)         lfsr <= '0;
    else if (!fill_we_i) lfsr <= {lfsr[`DC_LFSR_BITS-2:0],
                                  lfsr[`DC_LFSR_BITS-1] ~^ lfsr[`DC_LFSR_BITS-2]};
  end

  always_comb begin
    fill_way = dcache_pkg::ways_t'(1) << lfsr[`DC_WAY_BITS-1:0];  // Set full
    for (int w = `DC_WAYS-1; w >= 0; w--) begin
      if (!valid_q[w][lat_idx]) fill_way = dcache_pkg::ways_t'(1) << w;  // Lowest free way
    end
  end

  // --------------------------------------
  // Arrays
  // --------------------------------------
  always_ff @(posedge clk_i) begin
    if (rd_req_i) begin
      lat_idx <= rd_idx_i;
      lat_tag <= rd_tag_i;
    end
    for (int w = 0; w < `DC_WAYS; w++) begin
      if (fill_we_i && fill_way[w]) begin
        tag_mem[w][lat_idx]  <= lat_tag;
        data_mem[w][lat_idx] <= fill_line_i;
      end else if (wr_we_i && wr_ways_i[w]) begin
        data_mem[w][lat_idx][wr_offs_i*`DC_XLEN +: `DC_XLEN] <= wr_data_i;  // Write hit
      end
    end
  end

  // Valid bits, cleared by reset and by the sweep
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else begin
      for (int w = 0; w < `DC_WAYS; w++) begin
        if (flushing)                 valid_q[w][flush_cnt] <= 1'b0;
        else if (fill_we_i && fill_way[w]) valid_q[w][lat_idx] <= 1'b1;
      end
    end
  end

  // --------------------------------------
  // Invalidate sweep
  // --------------------------------------
  assign flush_done_o = flushing & (flush_cnt == dcache_pkg::idx_t'(`DC_SETS-1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      flushing  <= 1'b0;
      flush_cnt <= '0;
    end else if (flush_start_i) begin
      flushing  <= 1'b1;
      flush_cnt <= '0;
    end else if (flushing) begin
      flushing  <= ~flush_done_o;       // Stop after last set
      flush_cnt <= flush_cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: logic/dcache_setup.sv
// Request capture stage
//   Registers the CPU request when the front end is idle
//   One-cycle request pulse towards lookup and front end
//   Tag and index split for the memory lookup
`timescale 1ns/1ps
`default_nettype none

`include "dcache_consts.svh"

module dcache_setup (
  input  wire logic              clk_i,
  input  wire logic              rst_ni,

  input  wire logic              mem_req_i,
  input  wire logic              busy_i,          // Front end occupied
  input  wire dcache_pkg::word_t mem_adr_i,
  input  wire logic              mem_we_i,
  input  wire dcache_pkg::word_t mem_d_i,
  input  wire logic              is_cacheable_i,

  output logic                   req_o,           // One-cycle pulse
  output dcache_pkg::word_t      adr_o,
  output logic                   we_o,
  output dcache_pkg::word_t      d_o,
  output logic                   cacheable_o,
  output dcache_pkg::idx_t       rd_idx_o,
  output dcache_pkg::tag_t       rd_tag_o
);

  logic capture;

  assign capture = mem_req_i & ~busy_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) req_o <= 1'b0;
    else         req_o <= capture;
  end

  // Request fields, held until the next capture
  always_ff @(posedge clk_i) begin
    if (capture) begin
      adr_o       <= mem_adr_i;
      we_o        <= mem_we_i;
      d_o         <= mem_d_i;
      cacheable_o <= is_cacheable_i;
    end
  end

  // Address split for lookup
  assign rd_idx_o = adr_o[`DC_BYTE_BITS + `DC_OFFS_BITS +: `DC_IDX_BITS];
  assign rd_tag_o = adr_o[`DC_XLEN-1 -: `DC_TAG_BITS];

endmodule

`default_nettype wire

// File: logic/dcache_pkg.sv
// Data cache shared types
//   Address-field, line and way vectors
//   Bus command encoding
//   Front-end and bus-controller FSM states
`default_nettype none

`include "dcache_consts.svh"

package dcache_pkg;

  typedef logic [`DC_XLEN     -1:0] word_t;  // Data or address word
  typedef logic [`DC_TAG_BITS -1:0] tag_t;   // Address tag
  typedef logic [`DC_IDX_BITS -1:0] idx_t;   // Set index
  typedef logic [`DC_OFFS_BITS-1:0] offs_t;  // Word within line
  typedef logic [`DC_LINE_BITS-1:0] line_t;  // One cache line
  typedef logic [`DC_WAYS     -1:0] ways_t;  // One-hot way vector

  // Commands from front end to bus controller
  typedef enum logic [1:0] {
    BIUCMD_NONE,
    BIUCMD_READ_SINGLE,   // Non-cacheable read
    BIUCMD_READ_BURST,    // Line fill
    BIUCMD_WRITE_SINGLE   // Write-through
  } biucmd_t;

  typedef enum logic [2:0] {
    HIT_IDLE,
    HIT_LOOKUP,   // Tags compared this cycle
    HIT_BUSWAIT,  // Bus transfer running
    HIT_ACK,      // Waiting for req to drop
    HIT_FLUSH     // Invalidate sweep and flush handshake
  } hit_state_t;

  typedef enum logic [1:0] {
    BIU_IDLE,
    BIU_STROBE,   // Strobe held until accepted
    BIU_BEATS,    // Counting data beats
    BIU_DONE      // Command ack cycle
  } biu_state_t;

endpackage

`default_nettype wire

// File: logic/dcache_consts.svh
// Data cache geometry constants
//   Word width, words per line (also burst length)
//   Set and way counts, replacement LFSR width
//   Derived address-field and line widths
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// --------------------------------------
// Base geometry
// --------------------------------------
`define DC_XLEN       32   // Data and address width
`define DC_WORDS      4    // Words per line, burst length
`define DC_SETS       16   // Number of sets
`define DC_WAYS       2    // Associativity
`define DC_LFSR_BITS  7    // Victim LFSR width

// --------------------------------------
// Derived widths
// --------------------------------------
`define DC_BYTE_BITS  2                                  // Byte in word
`define DC_OFFS_BITS  $clog2(`DC_WORDS)                  // Word in line
`define DC_IDX_BITS   $clog2(`DC_SETS)                   // Set index
`define DC_TAG_BITS   (`DC_XLEN - `DC_BYTE_BITS - `DC_OFFS_BITS - `DC_IDX_BITS)
`define DC_LINE_BITS  (`DC_XLEN * `DC_WORDS)             // Whole line
`define DC_WAY_BITS   $clog2(`DC_WAYS)                   // Way number

`endif
